//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- ex_alu.sv
`default_nettype none

module ex_alu import rv_isa_pkg::*, ex_cfg_pkg::*; (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    op_valid,
    input  wire  [xlen-1:0]        op_a,
    input  wire  [xlen-1:0]        op_b,
    input  wire  alu_op_t          op_alu_op,
    input  wire  [tag_width-1:0]   op_inst_type,
    input  wire  [tag_width-1:0]   op_start_cycle,
    input  wire                    buf_accept,
    output logic                   alu_accept,
    output logic                   alu_valid,
    output logic [xlen-1:0]        res_value,
    output logic                   res_zero,
    output logic                   res_less,
    output logic [tag_width-1:0]   res_inst_type,
    output logic [tag_width-1:0]   res_start_cycle
);

    logic [xlen-1:0] alu_out;
    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;
    logic            less_out;
    logic            load;

    assign shamt       = op_b[4:0]; // rv32i shifts ignore the upper bits.
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (op_alu_op)
            alu_add:  alu_out = op_a + op_b;
            alu_sub:  alu_out = op_a - op_b;
            alu_and:  alu_out = op_a & op_b;
            alu_or:   alu_out = op_a | op_b;
            alu_xor:  alu_out = op_a ^ op_b;
            alu_slt:  alu_out = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: alu_out = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_sll:  alu_out = op_a << shamt;
            alu_srl:  alu_out = op_a >> shamt;
            alu_sra:  alu_out = $unsigned($signed(op_a) >>> shamt);
            default:  alu_out = '0;
        endcase
    end

    // branch unit reads less as unsigned only for sltu.
    assign less_out = (op_alu_op == alu_sltu) ? lt_unsigned : lt_signed;

    assign alu_accept = !alu_valid || buf_accept;
    assign load       = op_valid && alu_accept;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alu_valid <= 1'b0;
        end else if (alu_accept) begin
            alu_valid <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            res_value       <= alu_out;
            res_zero        <= (alu_out == '0);
            res_less        <= less_out;
            res_inst_type   <= op_inst_type;
            res_start_cycle <= op_start_cycle;
        end
    end

endmodule

`default_nettype wire

//--- ex_cfg_pkg.sv
`default_nettype none

package ex_cfg_pkg;

    localparam int tag_width = 32; // inst_type and start_cycle sidebands.
    localparam int buf_depth = 2;

    // occupancy of the result queue.
    typedef enum logic [1:0] {
        buf_empty = 2'd0,
        buf_one   = 2'd1,
        buf_full  = 2'd2
    } buf_state_t;

endpackage

`default_nettype wire

//--- ex_operand_select.sv
`default_nettype none

module ex_operand_select import rv_isa_pkg::*, ex_cfg_pkg::*; (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    id_valid,
    input  wire  [6:0]             opcode,
    input  wire  [xlen-1:0]        rs1_val,
    input  wire  [xlen-1:0]        rs2_val,
    input  wire  [xlen-1:0]        imm,
    input  wire  alu_op_t          alu_op,
    input  wire  [tag_width-1:0]   id_inst_type,
    input  wire  [tag_width-1:0]   id_start_cycle,
    input  wire                    alu_accept,
    output logic                   ex_ready,
    output logic                   op_valid,
    output logic [xlen-1:0]        op_a,
    output logic [xlen-1:0]        op_b,
    output alu_op_t                op_alu_op,
    output logic [tag_width-1:0]   op_inst_type,
    output logic [tag_width-1:0]   op_start_cycle
);

    opcode_class_t op_class;
    logic          use_rs2;
    logic          load;

    assign op_class = opcode_class_t'(opcode[6:2]);
    assign use_rs2  = (op_class == inst_r) || (op_class == inst_b); // register-register forms.

    // the slot frees up in the same cycle the alu takes its contents.
    assign ex_ready = !op_valid || alu_accept;
    assign load     = id_valid && ex_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op_valid <= 1'b0;
        end else if (ex_ready) begin
            op_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            op_a           <= rs1_val;
            op_b           <= use_rs2 ? rs2_val : imm;
            op_alu_op      <= alu_op;
            op_inst_type   <= id_inst_type;
            op_start_cycle <= id_start_cycle;
        end
    end

endmodule

`default_nettype wire

//--- ex_result_buffer.sv
`default_nettype none

module ex_result_buffer import rv_isa_pkg::*, ex_cfg_pkg::*; (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    alu_valid,
    input  wire  [xlen-1:0]        res_value,
    input  wire                    res_zero,
    input  wire                    res_less,
    input  wire  [tag_width-1:0]   res_inst_type,
    input  wire  [tag_width-1:0]   res_start_cycle,
    input  wire                    mem_ready,
    output logic                   buf_accept,
    output logic                   ex_valid,
    output logic [xlen-1:0]        alu_result,
    output logic                   alu_zero,
    output logic                   alu_less,
    output logic [tag_width-1:0]   ex_inst_type,
    output logic [tag_width-1:0]   ex_start_cycle
);

    buf_state_t state;
    buf_state_t state_next;

    logic [xlen-1:0]      value_mem [buf_depth];
    logic                 zero_mem  [buf_depth];
    logic                 less_mem  [buf_depth];
    logic [tag_width-1:0] type_mem  [buf_depth];
    logic [tag_width-1:0] start_mem [buf_depth];

    logic [$clog2(buf_depth)-1:0] wr_ptr;
    logic [$clog2(buf_depth)-1:0] rd_ptr;
    logic                         push;
    logic                         pop;

    assign buf_accept = (state != buf_full);
    assign ex_valid   = (state != buf_empty);
    assign push       = alu_valid && buf_accept;
    assign pop        = ex_valid && mem_ready;

    always_comb begin
        state_next = state;
        case (state)
            buf_empty: if (push) state_next = buf_one;
            buf_one: begin
                if (push && !pop) begin
                    state_next = buf_full;
                end else if (pop && !push) begin
                    state_next = buf_empty;
                end
            end
            buf_full:  if (pop) state_next = buf_one; // no push while full.
            default:   state_next = buf_empty;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= buf_empty;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            state <= state_next;
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            value_mem[wr_ptr] <= res_value;
            zero_mem[wr_ptr]  <= res_zero;
            less_mem[wr_ptr]  <= res_less;
            type_mem[wr_ptr]  <= res_inst_type;
            start_mem[wr_ptr] <= res_start_cycle;
        end
    end

    // head entry is always the oldest result.
    assign alu_result     = value_mem[rd_ptr];
    assign alu_zero       = zero_mem[rd_ptr];
    assign alu_less       = less_mem[rd_ptr];
    assign ex_inst_type   = type_mem[rd_ptr];
    assign ex_start_cycle = start_mem[rd_ptr];

endmodule

`default_nettype wire

//--- ex_stage.sv
`default_nettype none

module ex_stage import rv_isa_pkg::*, ex_cfg_pkg::*; (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    id_valid,
    output logic                   ex_ready,
    input  wire  [6:0]             opcode,
    input  wire  [xlen-1:0]        rs1_val,
    input  wire  [xlen-1:0]        rs2_val,
    input  wire  [xlen-1:0]        imm,
    input  wire  alu_op_t          alu_op,
    input  wire  [tag_width-1:0]   id_inst_type,
    input  wire  [tag_width-1:0]   id_start_cycle,
    input  wire                    mem_ready,
    output logic                   ex_valid,
    output logic [xlen-1:0]        alu_result,
    output logic                   alu_zero,
    output logic                   alu_less,
    output logic [tag_width-1:0]   ex_inst_type,
    output logic [tag_width-1:0]   ex_start_cycle
);

    logic                 op_valid;
    logic [xlen-1:0]      op_a;
    logic [xlen-1:0]      op_b;
    alu_op_t              op_alu_op;
    logic [tag_width-1:0] op_inst_type;
    logic [tag_width-1:0] op_start_cycle;
    logic                 alu_accept;

    logic                 alu_valid;
    logic [xlen-1:0]      res_value;
    logic                 res_zero;
    logic                 res_less;
    logic [tag_width-1:0] res_inst_type;
    logic [tag_width-1:0] res_start_cycle;
    logic                 buf_accept;

    ex_operand_select ex_operand_select_inst (
        .clk            (clk),
        .reset          (reset),
        .id_valid       (id_valid),
        .opcode         (opcode),
        .rs1_val        (rs1_val),
        .rs2_val        (rs2_val),
        .imm            (imm),
        .alu_op         (alu_op),
        .id_inst_type   (id_inst_type),
        .id_start_cycle (id_start_cycle),
        .alu_accept     (alu_accept),
        .ex_ready       (ex_ready),
        .op_valid       (op_valid),
        .op_a           (op_a),
        .op_b           (op_b),
        .op_alu_op      (op_alu_op),
        .op_inst_type   (op_inst_type),
        .op_start_cycle (op_start_cycle)
    );

    ex_alu ex_alu_inst (
        .clk             (clk),
        .reset           (reset),
        .op_valid        (op_valid),
        .op_a            (op_a),
        .op_b            (op_b),
        .op_alu_op       (op_alu_op),
        .op_inst_type    (op_inst_type),
        .op_start_cycle  (op_start_cycle),
        .buf_accept      (buf_accept),
        .alu_accept      (alu_accept),
        .alu_valid       (alu_valid),
        .res_value       (res_value),
        .res_zero        (res_zero),
        .res_less        (res_less),
        .res_inst_type   (res_inst_type),
        .res_start_cycle (res_start_cycle)
    );

    ex_result_buffer ex_result_buffer_inst (
        .clk             (clk),
        .reset           (reset),
        .alu_valid       (alu_valid),
        .res_value       (res_value),
        .res_zero        (res_zero),
        .res_less        (res_less),
        .res_inst_type   (res_inst_type),
        .res_start_cycle (res_start_cycle),
        .mem_ready       (mem_ready),
        .buf_accept      (buf_accept),
        .ex_valid        (ex_valid),
        .alu_result      (alu_result),
        .alu_zero        (alu_zero),
        .alu_less        (alu_less),
        .ex_inst_type    (ex_inst_type),
        .ex_start_cycle  (ex_start_cycle)
    );

endmodule

`default_nettype wire

//--- ex_stage_props.sv
`default_nettype none

module ex_stage_props import rv_isa_pkg::*, ex_cfg_pkg::*; #(
    parameter bit buffer_side = 1'b1
) (
    input wire                  clk,
    input wire                  reset,
    input wire                  mem_ready,
    input wire                  ex_valid,
    input wire [xlen-1:0]       alu_result,
    input wire                  alu_zero,
    input wire                  alu_less,
    input wire [tag_width-1:0]  ex_inst_type,
    input wire [tag_width-1:0]  ex_start_cycle,
    input wire buf_state_t      state,
    input wire                  buf_accept,
    input wire                  ex_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    generate
        if (buffer_side) begin : g_buffer
            assert property (@(posedge clk) disable iff (reset)
                ex_valid && !mem_ready |=> ex_valid && $stable(alu_result)
                    && $stable(alu_zero) && $stable(alu_less)
                    && $stable(ex_inst_type) && $stable(ex_start_cycle))
                else $error("output changed while stalled");
            assert property (@(posedge clk) disable iff (reset)
                state == buf_empty |-> !ex_valid)
                else $error("ex_valid high in empty buffer");
            assert property (@(posedge clk) disable iff (reset)
                (state == buf_full) == !buf_accept)
                else $error("buf_accept disagrees with buffer state");
        end else begin : g_operand
            assert property (@(posedge clk) $fell(reset) |-> ex_ready)
                else $error("ex_ready low after reset");
        end
    endgenerate

endmodule

bind ex_result_buffer ex_stage_props #(.buffer_side(1'b1)) buffer_props_inst (
    .clk(clk), .reset(reset), .mem_ready(mem_ready), .ex_valid(ex_valid),
    .alu_result(alu_result), .alu_zero(alu_zero), .alu_less(alu_less),
    .ex_inst_type(ex_inst_type), .ex_start_cycle(ex_start_cycle),
    .state(state), .buf_accept(buf_accept), .ex_ready(1'b1)
);

bind ex_operand_select ex_stage_props #(.buffer_side(1'b0)) operand_props_inst (
    .clk(clk), .reset(reset), .mem_ready(1'b1), .ex_valid(1'b0),
    .alu_result('0), .alu_zero(1'b0), .alu_less(1'b0),
    .ex_inst_type('0), .ex_start_cycle('0),
    .state(ex_cfg_pkg::buf_empty), .buf_accept(1'b1), .ex_ready(ex_ready)
);

`default_nettype wire

//--- rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int xlen = 32;

    // values are opcode bits 6:2 of the base rv32i encodings.
    typedef enum logic [4:0] {
        inst_load  = 5'b00000,
        inst_i     = 5'b00100,
        inst_auipc = 5'b00101,
        inst_store = 5'b01000,
        inst_r     = 5'b01100,
        inst_lui   = 5'b01101,
        inst_b     = 5'b11000,
        inst_jalr  = 5'b11001,
        inst_jal   = 5'b11011
    } opcode_class_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,
        alu_sltu = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_op_t; // codes 10 to 15 are unused and give a zero result.

endpackage

`default_nettype wire

//--- src.f
rv_isa_pkg.sv
ex_cfg_pkg.sv
ex_operand_select.sv
ex_alu.sv
ex_result_buffer.sv
ex_stage.sv
ex_stage_props.sv
tb_ex_stage.sv

//--- tb_ex_stage.sv
`default_nettype none

module tb_ex_stage import rv_isa_pkg::*, ex_cfg_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [6:0] opc_r    = 7'b0110011;
    localparam logic [6:0] opc_i    = 7'b0010011;
    localparam logic [6:0] opc_b    = 7'b1100011;
    localparam logic [6:0] opc_load = 7'b0000011;
    localparam int         wait_max = 40;

    logic                 clk;
    logic                 reset;
    logic                 id_valid;
    logic                 ex_ready;
    logic [6:0]           opcode;
    logic [xlen-1:0]      rs1_val;
    logic [xlen-1:0]      rs2_val;
    logic [xlen-1:0]      imm;
    alu_op_t              alu_op;
    logic [tag_width-1:0] id_inst_type;
    logic [tag_width-1:0] id_start_cycle;
    logic                 mem_ready;
    logic                 ex_valid;
    logic [xlen-1:0]      alu_result;
    logic                 alu_zero;
    logic                 alu_less;
    logic [tag_width-1:0] ex_inst_type;
    logic [tag_width-1:0] ex_start_cycle;

    logic [xlen-1:0]      exp_value[$];
    bit                   exp_zero[$];
    bit                   exp_less[$];
    logic [tag_width-1:0] exp_type[$];
    logic [tag_width-1:0] exp_start[$];

    int   errors;
    int   passed;
    int   failed;
    int   cycle;
    int   seed;

    ex_stage ex_stage_inst (.*);

    always #50 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [xlen-1:0] model_result(input logic [xlen-1:0] a,
                                                     input logic [xlen-1:0] b,
                                                     input alu_op_t op);
        logic signed [xlen-1:0] sa;
        sa = a;
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_slt:  return ($signed(a) < $signed(b)) ? 1 : 0;
            alu_sltu: return (a < b) ? 1 : 0;
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return sa >>> b[4:0];
            default:  return '0;
        endcase
    endfunction

    task automatic check_result(input string name, input logic [xlen-1:0] exp,
                                input logic [xlen-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input bit exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_tag(input string name, input logic [tag_width-1:0] exp,
                             input logic [tag_width-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_op(input string name, input alu_op_t exp, input alu_op_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    // memory-side monitor, compares every transfer with the oldest expected result.
    always @(posedge clk) begin
        if (!reset && ex_valid && mem_ready) begin
            if (exp_value.size() == 0) begin
                $display("unexpected result %h with no instruction outstanding", alu_result);
                errors++;
            end else begin
                check_result("alu_result", exp_value.pop_front(), alu_result);
                check_flag("alu_zero", exp_zero.pop_front(), alu_zero);
                check_flag("alu_less", exp_less.pop_front(), alu_less);
                check_op("ex_inst_type[3:0]", alu_op_t'(exp_type[0][3:0]),
                         alu_op_t'(ex_inst_type[3:0]));
                check_tag("ex_inst_type", exp_type.pop_front(), ex_inst_type);
                check_tag("ex_start_cycle", exp_start.pop_front(), ex_start_cycle);
            end
        end
    end

    // offers one instruction and returns once it is taken or max_wait edges pass.
    task automatic issue(input logic [6:0] opc, input logic [xlen-1:0] a,
                         input logic [xlen-1:0] b, input logic [xlen-1:0] im,
                         input alu_op_t op, input int max_wait, output bit taken);
        logic [xlen-1:0] opb;
        int              waited;
        @(negedge clk);
        id_valid       = 1'b1;
        opcode         = opc;
        rs1_val        = a;
        rs2_val        = b;
        imm            = im;
        alu_op         = op;
        id_inst_type   = {17'h0, opc, 4'h0, op};
        id_start_cycle = cycle;
        opb = (opc == opc_r || opc == opc_b) ? b : im;
        taken  = 1'b0;
        waited = 0;
        while (!taken && waited < max_wait) begin
            @(posedge clk);
            if (ex_ready) taken = 1'b1;
            else waited++;
        end
        if (taken) begin
            exp_value.push_back(model_result(a, opb, op));
            exp_zero.push_back(model_result(a, opb, op) == 0);
            exp_less.push_back(op == alu_sltu ? a < opb : $signed(a) < $signed(opb));
            exp_type.push_back(id_inst_type);
            exp_start.push_back(id_start_cycle);
        end
    endtask

    task automatic send(input logic [6:0] opc, input logic [xlen-1:0] a,
                        input logic [xlen-1:0] b, input logic [xlen-1:0] im, input alu_op_t op);
        bit taken;
        issue(opc, a, b, im, op, wait_max, taken);
        if (!taken) begin
            $display("timeout: the stage never accepted an instruction");
            errors++;
        end
    endtask

    task automatic go_idle();
        @(negedge clk);
        id_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_value.size() != 0 && waited < wait_max) begin
            @(posedge clk);
            waited++;
        end
        if (exp_value.size() != 0) begin
            $display("timeout: %0d results never came out", exp_value.size());
            errors++;
            exp_value.delete();
            exp_zero.delete();
            exp_less.delete();
            exp_type.delete();
            exp_start.delete();
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            passed++;
            $display("%s: pass", name);
        end else begin
            failed++;
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_reset();
        int e;
        e = errors;
        check_flag("ex_valid", 1'b0, ex_valid);
        check_flag("ex_ready", 1'b1, ex_ready);
        finish_test("reset", e);
    endtask

    task automatic test_ops();
        int e;
        e = errors;
        for (int op = 0; op < 10; op++) begin
            send(opc_r, 32'h8000_0001, 32'h0000_0021, 32'h0, alu_op_t'(op));
            send(opc_r, 32'h1234_5678, 32'h1234_5678, 32'h0, alu_op_t'(op));
            for (int k = 0; k < 4; k++) begin
                send(opc_r, $random(seed), $random(seed), $random(seed), alu_op_t'(op));
            end
        end
        go_idle();
        drain();
        finish_test("operations", e);
    endtask

    task automatic test_operand_select();
        int e;
        e = errors;
        send(opc_r, 32'h0000_0100, 32'h0000_0025, 32'h0000_0423, alu_add);
        send(opc_i, 32'h0000_0100, 32'h0000_0025, 32'h0000_0423, alu_add);
        send(opc_b, 32'hffff_fff0, 32'h0000_0025, 32'h0000_0423, alu_sub);
        send(opc_load, 32'h0000_0100, 32'h0000_0025, 32'h0000_0423, alu_add);
        send(opc_r, 32'h0000_0001, 32'h0000_0025, 32'h0000_0423, alu_sll); // shift by 5.
        send(opc_i, 32'h0000_0001, 32'h0000_0025, 32'h0000_0423, alu_sll); // shift by 3.
        send(opc_i, 32'h8000_0000, 32'h0, 32'hffff_ffff, alu_sra);
        go_idle();
        drain();
        finish_test("operand select", e);
    endtask

    task automatic test_tags();
        int e;
        e = errors;
        send(opc_i, 32'h5, 32'h0, 32'h7, alu_xor);
        go_idle();
        repeat (3) @(negedge clk); // spreads the start cycles apart.
        send(opc_r, 32'h5, 32'h5, 32'h0, alu_sub);
        go_idle();
        drain();
        finish_test("tags", e);
    endtask

    task automatic test_backpressure();
        int  e;
        int  taken_count;
        bit  taken;
        e = errors;
        taken_count = 0;
        @(negedge clk);
        mem_ready = 1'b0;
        for (int i = 0; i < 6; i++) begin
            issue(opc_r, 32'd10 * i, 32'd3, 32'h0, alu_add, 8, taken);
            if (taken) taken_count++;
            else go_idle(); // withdraw the offer before the next one changes the fields.
        end
        if (taken_count != 4) begin
            $display("FAIL accepted expected %h got %h", 4, taken_count);
            errors++;
        end
        check_flag("ex_ready", 1'b0, ex_ready);
        go_idle();
        mem_ready = 1'b1;
        drain();
        finish_test("back-pressure", e);
    endtask

    task automatic test_streaming();
        int e;
        bit taken;
        e = errors;
        for (int i = 0; i < 20; i++) begin
            issue(opc_r, $random(seed), $random(seed), 32'h0, alu_op_t'(i % 10), 1, taken);
            if (!taken) begin
                $display("instruction %0d of the stream was not accepted back to back", i);
                errors++;
            end
        end
        go_idle();
        drain();
        finish_test("streaming", e);
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        id_valid       = 1'b0;
        opcode         = '0;
        rs1_val        = '0;
        rs2_val        = '0;
        imm            = '0;
        alu_op         = alu_add;
        id_inst_type   = '0;
        id_start_cycle = '0;
        mem_ready      = 1'b1;
        errors = 0;
        passed = 0;
        failed = 0;
        cycle  = 0;
        seed   = 70;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_reset();
        test_ops();
        test_operand_select();
        test_tags();
        test_backpressure();
        test_streaming();
        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
